// ==== Bender.yml ====
package:
  name: ctrl_periph

sources:
  - files:
      - design/ctrl_pkg.sv
      - design/peri_decode.sv
      - design/uart_rx.sv
      - design/rx_byte_buffer.sv
      - design/uart_tx.sv
      - design/bus_response.sv
      - design/ctrl_periph_top.sv
  - target: simulation
    files:
      - bench/tb_ctrl_periph.sv

// ==== bench/tb_ctrl_periph.sv ====
// Self-checking testbench for the peripheral slave behind the CPU memory bus.
// Drives bus requests and serial frames, checks every answer with assertions.
`timescale 1ns/10ps

module tb_ctrl_periph import ctrl_pkg::*; ();

	localparam int FRAME_CYCLES = 10 * BAUD_DIV;
	// One sent frame, five received, two unanswered requests
	localparam int NUM_FRAMES = 8;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 4000;
	localparam bus_addr_t BAD_ADDR = 32'h0010_0000;

	logic clk;
	logic resetn;
	logic mem_valid;
	bus_addr_t mem_addr;
	bus_data_t mem_wdata;
	bus_strb_t mem_wstrb;
	logic mem_ready;
	bus_data_t mem_rdata;
	logic bus_error;
	logic rx;
	logic tx;
	btn_t btn;
	led_t led;
	logic tx_at_ready;
	led_t expected_led;
	uart_byte_t sent[5];

	ctrl_periph_top i_ctrl_periph_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("Failure: %s", what);
		fail_run();
	endtask

	task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
		assert (got === exp) else begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	// Answers are single-cycle pulses
	assert property (@(posedge clk) disable iff (!resetn) mem_ready |=> !mem_ready)
		else report_failure("mem_ready stayed high for more than one cycle");
	assert property (@(posedge clk) disable iff (!resetn) bus_error |=> bus_error)
		else report_failure("bus_error cleared without a reset");
	assert property (@(posedge clk) disable iff (!resetn) bus_error |-> !mem_ready)
		else report_failure("a request was answered while bus_error was set");

	// Holds the request until mem_ready or until limit cycles have passed
	task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
			input bus_strb_t wstrb, input int limit, output bus_data_t rdata,
			output int latency, output logic answered);
		int waited;
		waited = 0;
		answered = 1'b0;
		rdata = '0;
		@(posedge clk);
		mem_valid <= 1'b1;
		mem_addr <= addr;
		mem_wdata <= wdata;
		mem_wstrb <= wstrb;
		while (!answered && waited < limit) begin
			@(negedge clk);
			waited++;
			if (mem_ready) begin
				answered = 1'b1;
				rdata = mem_rdata;
				tx_at_ready = tx;
			end
		end
		latency = waited - 1;
		@(posedge clk);
		mem_valid <= 1'b0;
		mem_wstrb <= '0;
	endtask

	task automatic gpio_access(input bus_data_t wdata, input bus_strb_t wstrb);
		bus_data_t rdata;
		int latency;
		logic answered;
		bus_access(GPIO_ADDR, wdata, wstrb, 16, rdata, latency, answered);
		check_value("mem_ready seen", answered, 1);
		check_value("mem_ready latency", latency, 1);
		check_value("mem_rdata", rdata, {24'h0, btn, expected_led});
		if (wstrb[0])
			expected_led = wdata[4:0];
		@(negedge clk);
		check_value("led", led, expected_led);
	endtask

	// 8N1 frame on rx, LSB first
	task automatic send_frame(input uart_byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i];
			repeat (BAUD_DIV - 1) @(posedge clk);
		end
	endtask

	task automatic capture_frame(output uart_byte_t data);
		data = '0;
		while (tx !== 1'b0)
			@(negedge clk);
		repeat (BAUD_DIV / 2) @(negedge clk);
		check_value("tx start bit", tx, 0);
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_DIV) @(negedge clk);
			data[i] = tx;
		end
		repeat (BAUD_DIV) @(negedge clk);
		check_value("tx stop bit", tx, 1);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_failure("watchdog expired before the tests finished");
	end

	initial begin
		bus_data_t rdata;
		bus_data_t wdata;
		int latency;
		logic answered;
		uart_byte_t seen;

		void'($urandom(32'h2473_e815));
		resetn <= 1'b0;
		mem_valid <= 1'b0;
		mem_addr <= '0;
		mem_wdata <= '0;
		mem_wstrb <= '0;
		rx <= 1'b1;
		btn <= btn_t'($urandom);
		expected_led = '0;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_value("mem_ready", mem_ready, 0);
		check_value("bus_error", bus_error, 0);
		check_value("tx", tx, 1);
		check_value("led", led, 0);

		gpio_access($urandom, 4'b0001);
		gpio_access($urandom, 4'b1110);
		gpio_access($urandom, 4'b0000);
		gpio_access($urandom, 4'b1111);

		wdata = $urandom;
		fork
			bus_access(UART_ADDR, wdata, 4'b0001, 2 * FRAME_CYCLES, rdata, latency, answered);
			capture_frame(seen);
		join
		check_value("mem_ready seen", answered, 1);
		check_value("tx at mem_ready", tx_at_ready, 1);
		check_value("tx byte", seen, wdata[7:0]);

		// Fifth byte finds the buffer full and is dropped
		for (int i = 0; i < 5; i++) begin
			sent[i] = uart_byte_t'($urandom);
			send_frame(sent[i]);
		end
		repeat (BAUD_DIV) @(posedge clk);
		for (int i = 0; i < 4; i++) begin
			bus_access(UART_ADDR, '0, '0, 16, rdata, latency, answered);
			check_value("mem_ready seen", answered, 1);
			check_value("mem_rdata", rdata, {24'h0, sent[i]});
		end
		bus_access(UART_ADDR, '0, '0, 16, rdata, latency, answered);
		check_value("mem_rdata", rdata, 32'hffff_ffff);

		bus_access(BAD_ADDR, '0, '0, FRAME_CYCLES, rdata, latency, answered);
		check_value("mem_ready seen", answered, 0);
		check_value("bus_error", bus_error, 1);
		bus_access(GPIO_ADDR, '0, '0, FRAME_CYCLES, rdata, latency, answered);
		check_value("mem_ready seen", answered, 0);
		@(posedge clk);
		resetn <= 1'b0;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		expected_led = '0;
		@(negedge clk);
		check_value("bus_error", bus_error, 0);
		gpio_access($urandom, 4'b0001);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== design/bus_response.sv ====
// Response stage of the slave, also home of the LED register.
// Merges the ready pulses and picks the read word that goes with them.
`timescale 1ns/10ps

module bus_response import ctrl_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      gpio_sel,
	input  logic      rx_ready,
	input  logic      tx_ready,
	input  bus_strb_t mem_wstrb,
	input  bus_data_t mem_wdata,
	input  bus_data_t rx_rdata,
	input  btn_t      btn,
	output led_t      led,
	output logic      mem_ready,
	output bus_data_t mem_rdata
);

	logic gpio_ready;
	bus_data_t gpio_rdata;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			gpio_ready <= 1'b0;
			led <= '0;
		end else begin
			gpio_ready <= gpio_sel;
			if (gpio_sel && mem_wstrb[0])
				led <= mem_wdata[4:0];
		end
	end

	// Read back shows the LEDs as they were before this access
	always_ff @(posedge clk) begin
		if (gpio_sel)
			gpio_rdata <= bus_data_t'({btn, led});
	end

	assign mem_ready = gpio_ready || rx_ready || tx_ready;

	// Writes to the serial port carry no data back
	always_comb begin
		if (gpio_ready)
			mem_rdata = gpio_rdata;
		else if (rx_ready)
			mem_rdata = rx_rdata;
		else
			mem_rdata = '0;
	end

endmodule

// ==== design/ctrl_periph_top.sv ====
// Peripheral slave behind the CPU memory bus: LED/button register and serial port.
// Answers with a one-cycle mem_ready, unmapped addresses raise a sticky bus_error.
`timescale 1ns/10ps

module ctrl_periph_top import ctrl_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      mem_valid,
	input  bus_addr_t mem_addr,
	input  bus_data_t mem_wdata,
	input  bus_strb_t mem_wstrb,
	output logic      mem_ready,
	output bus_data_t mem_rdata,
	output logic      bus_error,
	input  logic      rx,
	output logic      tx,
	input  btn_t      btn,
	output led_t      led
);

	logic gpio_sel;
	logic rx_pop;
	logic tx_start;
	logic rx_valid;
	uart_byte_t rx_byte;
	logic rx_ready;
	bus_data_t rx_rdata;
	logic tx_ready;

	peri_decode i_peri_decode (
		.clk       (clk),
		.resetn    (resetn),
		.mem_valid (mem_valid),
		.mem_ready (mem_ready),
		.mem_addr  (mem_addr),
		.mem_wstrb (mem_wstrb),
		.gpio_sel  (gpio_sel),
		.rx_pop    (rx_pop),
		.tx_start  (tx_start),
		.bus_error (bus_error)
	);

	uart_rx i_uart_rx (
		.clk      (clk),
		.resetn   (resetn),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	rx_byte_buffer i_rx_byte_buffer (
		.clk      (clk),
		.resetn   (resetn),
		.rx_valid (rx_valid),
		.rx_pop   (rx_pop),
		.rx_byte  (rx_byte),
		.rx_ready (rx_ready),
		.rx_rdata (rx_rdata)
	);

	uart_tx i_uart_tx (
		.clk       (clk),
		.resetn    (resetn),
		.tx_start  (tx_start),
		.mem_wdata (mem_wdata),
		.tx        (tx),
		.tx_ready  (tx_ready)
	);

	bus_response i_bus_response (
		.clk       (clk),
		.resetn    (resetn),
		.gpio_sel  (gpio_sel),
		.rx_ready  (rx_ready),
		.tx_ready  (tx_ready),
		.mem_wstrb (mem_wstrb),
		.mem_wdata (mem_wdata),
		.rx_rdata  (rx_rdata),
		.btn       (btn),
		.led       (led),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

endmodule

// ==== design/ctrl_pkg.sv ====
// Shared widths, register addresses and serial timing for the peripheral slave.
// Every design file imports this package in its module header.
package ctrl_pkg;

	// Bus side
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0] bus_strb_t;

	// Board side
	typedef logic [7:0] uart_byte_t;
	typedef logic [4:0] led_t;
	typedef logic [2:0] btn_t;

	localparam bus_addr_t GPIO_ADDR = 32'h0200_0000;
	localparam bus_addr_t UART_ADDR = 32'h0200_0004;

	// 12 MHz clock, 115200 baud
	localparam int BAUD_DIV = 104;
	localparam int RX_DEPTH = 4;

	// Counter wide enough for one full bit period
	typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;
	typedef logic [$clog2(RX_DEPTH)-1:0] rx_slot_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

// ==== design/peri_decode.sv ====
// Bus address decoder for the peripheral slave.
// Turns a pending request into one strobe per peripheral and latches bus errors.
`timescale 1ns/10ps

module peri_decode import ctrl_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      mem_valid,
	input  logic      mem_ready,
	input  bus_addr_t mem_addr,
	input  bus_strb_t mem_wstrb,
	output logic      gpio_sel,
	output logic      rx_pop,
	output logic      tx_start,
	output logic      bus_error
);

	logic req;
	logic hit_gpio;
	logic hit_uart;
	logic is_write;

	// A request is live until its ready pulse, and never after an error
	assign req = mem_valid && !mem_ready && !bus_error;

	assign hit_gpio = (mem_addr == GPIO_ADDR);
	assign hit_uart = (mem_addr == UART_ADDR);
	assign is_write = |mem_wstrb;

	assign gpio_sel = req && hit_gpio;
	assign rx_pop = req && hit_uart && !is_write;
	assign tx_start = req && hit_uart && is_write;

	// Sticky until reset, so the master stalls on a bad access
	always_ff @(posedge clk) begin
		if (!resetn) begin
			bus_error <= 1'b0;
		end else if (req && !hit_gpio && !hit_uart) begin
			bus_error <= 1'b1;
		end
	end

endmodule

// ==== design/rx_byte_buffer.sv ====
// Receive buffer holding up to RX_DEPTH bytes, oldest in the low byte.
// Bus reads pop one byte and get all ones when nothing is waiting.
`timescale 1ns/10ps

module rx_byte_buffer import ctrl_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       rx_valid,
	input  logic       rx_pop,
	input  uart_byte_t rx_byte,
	output logic       rx_ready,
	output bus_data_t  rx_rdata
);

	bus_data_t byte_word;
	logic [RX_DEPTH-1:0] byte_vld;
	rx_slot_t wr_slot;

	// Valid flags fill from bit 0 up, so the first hole is the next slot
	always_comb begin
		wr_slot = '0;
		for (int i = RX_DEPTH - 1; i >= 0; i--)
			if (!byte_vld[i])
				wr_slot = rx_slot_t'(i);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			byte_vld <= '0;
			rx_ready <= 1'b0;
		end else begin
			rx_ready <= 1'b0;
			// Incoming byte wins, a pending pop waits a cycle
			if (rx_valid) begin
				byte_vld <= {byte_vld[RX_DEPTH-2:0], 1'b1};
			end else if (rx_pop) begin
				byte_vld <= byte_vld >> 1;
				rx_ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			if (!(&byte_vld))
				byte_word[wr_slot*8 +: 8] <= rx_byte;
		end else if (rx_pop) begin
			byte_word <= byte_word >> 8;
			rx_rdata <= byte_vld[0] ? bus_data_t'(byte_word[7:0]) : '1;
		end
	end

endmodule

// ==== design/uart_rx.sv ====
// Serial receiver, 8N1 at BAUD_DIV clocks per bit.
// Emits each byte with a one-cycle rx_valid at the middle of its stop bit.
`timescale 1ns/10ps

module uart_rx import ctrl_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       rx,
	output logic       rx_valid,
	output uart_byte_t rx_byte
);

	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	rx_state_t state;
	baud_cnt_t cnt;
	logic [3:0] bit_cnt;
	uart_byte_t shreg;

	assign rx_byte = shreg;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
			state <= RX_IDLE;
			rx_valid <= 1'b0;
			cnt <= '0;
			bit_cnt <= '0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
			rx_valid <= 1'b0;
			if (cnt != '0)
				cnt <= cnt - 1'b1;

			case (state)
				RX_IDLE: begin
					// Wait half a bit from the falling start edge
					if (rx_last && !rx_sync) begin
						cnt <= baud_cnt_t'(BAUD_DIV / 2);
						bit_cnt <= '0;
						state <= RX_DATA;
					end
				end
				RX_DATA: begin
					// Start bit is shifted in first and falls out after eight more
					if (cnt == '0) begin
						shreg <= {rx_sync, shreg[7:1]};
						cnt <= baud_cnt_t'(BAUD_DIV - 1);
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd8)
							state <= RX_STOP;
					end
				end
				default: begin
					// Drop the byte on a framing error
					if (cnt == '0) begin
						rx_valid <= rx_sync;
						state <= RX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== design/uart_tx.sv ====
// Serial transmitter, 8N1 on a free-running baud divider.
// A held write starts a frame at the next tick, tx_ready marks the stop bit.
`timescale 1ns/10ps

module uart_tx import ctrl_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      tx_start,
	input  bus_data_t mem_wdata,
	output logic      tx,
	output logic      tx_ready
);

	baud_cnt_t div_cnt;
	logic tick;
	tx_state_t state;
	uart_byte_t shreg;
	logic [2:0] bit_cnt;

	assign tick = (div_cnt == baud_cnt_t'(BAUD_DIV - 1));

	always_ff @(posedge clk) begin
		if (!resetn)
			div_cnt <= '0;
		else
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= TX_IDLE;
			tx <= 1'b1;
			tx_ready <= 1'b0;
			bit_cnt <= '0;
		end else begin
			tx_ready <= 1'b0;
			if (tick) begin
				case (state)
					TX_START: begin
						tx <= shreg[0];
						shreg <= shreg >> 1;
						bit_cnt <= '0;
						state <= TX_DATA;
					end
					TX_DATA: begin
						if (bit_cnt == 3'd7) begin
							tx <= 1'b1;
							tx_ready <= 1'b1;
							state <= TX_STOP;
						end else begin
							tx <= shreg[0];
							shreg <= shreg >> 1;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					// Stop bit has run a full period once this tick arrives
					default: begin
						if (tx_start) begin
							tx <= 1'b0;
							shreg <= mem_wdata[7:0];
							state <= TX_START;
						end else begin
							state <= TX_IDLE;
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== sources.f ====
design/ctrl_pkg.sv
design/peri_decode.sv
design/uart_rx.sv
design/rx_byte_buffer.sv
design/uart_tx.sv
design/bus_response.sv
design/ctrl_periph_top.sv
bench/tb_ctrl_periph.sv
